//--- bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Reset held low over the first two rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- bench/frontend_assertions.sv
`timescale 1ns/1ps

module frontend_assertions #(
    parameter int DEPTH = 32
) (
    input logic                     clk,
    input logic                     rst_n_i,
    input logic [$clog2(DEPTH):0]   count_i,
    input logic [1:0]               wr_count_i,
    input logic                     flush_i
);

    localparam int CNT_W = $clog2(DEPTH) + 1;

    // Occupancy stays within the array
    count_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        count_i <= CNT_W'(DEPTH))
        else $error("buffer count %0d above depth %0d", count_i, DEPTH);

    // Fetch side holds off while the buffer is full
    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        (count_i == CNT_W'(DEPTH)) && !flush_i |-> wr_count_i == 2'd0)
        else $error("write of %0d entries into a full buffer", wr_count_i);

    flush_empties: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> count_i == '0)
        else $error("buffer count %0d after flush", count_i);

endmodule

//--- bench/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;

    localparam int DEPTH       = 32;
    localparam int RESET_LIMIT = 20;
    localparam int DRAIN_LIMIT = 2 * DEPTH + 8;

    localparam logic [5:0] OPC_B   = 6'h14;
    localparam logic [5:0] OPC_BL  = 6'h15;
    localparam logic [5:0] OPC_BEQ = 6'h16;
    localparam logic [5:0] OPC_BNE = 6'h17;
    localparam logic [5:0] OPC_BLT = 6'h18;
    localparam logic [5:0] OPC_ALU = 6'h01;
    localparam logic [5:0] OPC_LD  = 6'h22;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic        is_br;
        logic        pt;
        logic [31:0] tgt;
    } exp_entry_t;

    typedef struct packed {
        logic [3:0] grp;
        logic [1:0] fen;
        logic [5:0] op0;
        logic [5:0] op1;
        logic       pt;
        logic [1:0] dr;
        logic       bfl;
        logic       efl;
        logic [5:0] rep;
    } step_t;

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    // group, fetch_en, opcode 0, opcode 1, pred taken, decode ready,
    // branch flush, exception flush, repeat count
    localparam int NUM_STEPS = 29;
    localparam step_t STEPS [NUM_STEPS] = '{
        '{4'd1, 2'b00, OPC_ALU, OPC_ALU, 1'b0, 2'b11, 1'b0, 1'b0, 6'd1},
        '{4'd1, 2'b11, OPC_ALU, OPC_LD,  1'b0, 2'b00, 1'b0, 1'b0, 6'd1},
        '{4'd1, 2'b01, OPC_LD,  OPC_ALU, 1'b0, 2'b00, 1'b0, 1'b0, 6'd1},
        '{4'd1, 2'b10, OPC_ALU, OPC_LD,  1'b0, 2'b00, 1'b0, 1'b0, 6'd1},
        '{4'd1, 2'b11, OPC_LD,  OPC_LD,  1'b0, 2'b01, 1'b0, 1'b0, 6'd1},
        '{4'd1, 2'b00, OPC_ALU, OPC_ALU, 1'b0, 2'b11, 1'b0, 1'b0, 6'd4},
        '{4'd2, 2'b11, OPC_BEQ, OPC_BNE, 1'b1, 2'b11, 1'b0, 1'b0, 6'd1},
        '{4'd2, 2'b01, OPC_BLT, OPC_ALU, 1'b1, 2'b11, 1'b0, 1'b0, 6'd1},
        '{4'd2, 2'b10, OPC_ALU, OPC_B,   1'b1, 2'b11, 1'b0, 1'b0, 6'd1},
        '{4'd2, 2'b11, OPC_BL,  OPC_ALU, 1'b1, 2'b01, 1'b0, 1'b0, 6'd1},
        '{4'd2, 2'b11, OPC_LD,  OPC_B,   1'b0, 2'b11, 1'b0, 1'b0, 6'd1},
        '{4'd2, 2'b00, OPC_ALU, OPC_ALU, 1'b0, 2'b11, 1'b0, 1'b0, 6'd3},
        '{4'd3, 2'b11, OPC_ALU, OPC_LD,  1'b0, 2'b00, 1'b0, 1'b0, 6'd2},
        '{4'd3, 2'b00, OPC_ALU, OPC_ALU, 1'b0, 2'b00, 1'b0, 1'b0, 6'd2},
        '{4'd3, 2'b00, OPC_ALU, OPC_ALU, 1'b0, 2'b01, 1'b0, 1'b0, 6'd1},
        '{4'd3, 2'b00, OPC_ALU, OPC_ALU, 1'b0, 2'b11, 1'b0, 1'b0, 6'd3},
        '{4'd3, 2'b01, OPC_LD,  OPC_ALU, 1'b0, 2'b00, 1'b0, 1'b0, 6'd1},
        '{4'd3, 2'b00, OPC_ALU, OPC_ALU, 1'b0, 2'b11, 1'b0, 1'b0, 6'd2},
        '{4'd4, 2'b11, OPC_ALU, OPC_BEQ, 1'b1, 2'b00, 1'b0, 1'b0, 6'd18},
        '{4'd4, 2'b11, OPC_LD,  OPC_ALU, 1'b0, 2'b01, 1'b0, 1'b0, 6'd2},
        '{4'd4, 2'b11, OPC_ALU, OPC_LD,  1'b0, 2'b11, 1'b0, 1'b0, 6'd4},
        '{4'd4, 2'b00, OPC_ALU, OPC_ALU, 1'b0, 2'b11, 1'b0, 1'b0, 6'd18},
        '{4'd5, 2'b11, OPC_ALU, OPC_LD,  1'b0, 2'b00, 1'b0, 1'b0, 6'd2},
        '{4'd5, 2'b00, OPC_ALU, OPC_ALU, 1'b0, 2'b11, 1'b1, 1'b0, 6'd1},
        '{4'd5, 2'b00, OPC_ALU, OPC_ALU, 1'b0, 2'b11, 1'b0, 1'b0, 6'd1},
        '{4'd5, 2'b11, OPC_LD,  OPC_ALU, 1'b0, 2'b00, 1'b0, 1'b0, 6'd1},
        '{4'd5, 2'b01, OPC_ALU, OPC_ALU, 1'b0, 2'b01, 1'b0, 1'b1, 6'd1},
        '{4'd5, 2'b11, OPC_BNE, OPC_ALU, 1'b1, 2'b11, 1'b0, 1'b0, 6'd2},
        '{4'd5, 2'b00, OPC_ALU, OPC_ALU, 1'b0, 2'b11, 1'b0, 1'b0, 6'd3}
    };

    logic        clk;
    logic        rst_n;
    logic [1:0]  fetch_en;
    logic [31:0] fetch_inst0;
    logic [31:0] fetch_pc0;
    logic [31:0] fetch_inst1;
    logic [31:0] fetch_pc1;
    logic        pred_taken;
    logic [31:0] pred_target;
    logic [1:0]  decode_ready;
    logic        branch_flush;
    logic        exc_flush;
    logic        fetch_ready;
    logic [1:0]  issue_valid;
    logic [31:0] issue_inst0;
    logic [31:0] issue_pc0;
    logic [31:0] issue_inst1;
    logic [31:0] issue_pc1;
    logic [1:0]  issue_is_branch;
    logic [1:0]  issue_pred_taken;
    logic [31:0] issue_pred_target0;
    logic [31:0] issue_pred_target1;

    // Reference model state
    exp_entry_t  model_q[$];
    logic        model_run;
    logic [1:0]  exp_valid;
    exp_entry_t  exp_out0;
    exp_entry_t  exp_out1;
    logic [31:0] pc_next;

    int grp_cur;
    int grp_checks;
    int grp_errors;
    int total_checks;
    int errors;
    int tests_run;
    int tests_failed;
    bit verdict_done;

    clk_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    frontend_top #(.DEPTH(DEPTH)) UUT (
        .clk                  (clk),
        .rst_n_i              (rst_n),
        .fetch_en_i           (fetch_en),
        .fetch_inst0_i        (fetch_inst0),
        .fetch_pc0_i          (fetch_pc0),
        .fetch_inst1_i        (fetch_inst1),
        .fetch_pc1_i          (fetch_pc1),
        .pred_taken_i         (pred_taken),
        .pred_target_i        (pred_target),
        .decode_ready_i       (decode_ready),
        .branch_flush_i       (branch_flush),
        .exc_flush_i          (exc_flush),
        .fetch_ready_o        (fetch_ready),
        .issue_valid_o        (issue_valid),
        .issue_inst0_o        (issue_inst0),
        .issue_pc0_o          (issue_pc0),
        .issue_inst1_o        (issue_inst1),
        .issue_pc1_o          (issue_pc1),
        .issue_is_branch_o    (issue_is_branch),
        .issue_pred_taken_o   (issue_pred_taken),
        .issue_pred_target0_o (issue_pred_target0),
        .issue_pred_target1_o (issue_pred_target1)
    );

    bind inst_buffer frontend_assertions #(.DEPTH(DEPTH)) u_assertions (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .count_i    (ibuf.count),
        .wr_count_i (ibuf.wr_count),
        .flush_i    (ibuf.flush)
    );

    function automatic logic opcode_is_branch(input logic [5:0] op);
        return op inside {OPC_B, OPC_BL, OPC_BEQ, OPC_BNE, OPC_BLT};
    endfunction

    function automatic string group_name(input int g);
        case (g)
            1:       return "order";
            2:       return "branch info";
            3:       return "back-pressure";
            4:       return "full buffer";
            default: return "flush";
        endcase
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        grp_checks++;
        total_checks++;
        if (got !== exp) begin
            grp_errors++;
            errors++;
            $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs(input logic exp_ready);
        check_field("fetch_ready_o", {31'b0, fetch_ready}, {31'b0, exp_ready});
        check_field("issue_valid_o", {30'b0, issue_valid}, {30'b0, exp_valid});
        check_field("issue_inst0_o", issue_inst0, exp_out0.inst);
        check_field("issue_pc0_o", issue_pc0, exp_out0.pc);
        check_field("issue_inst1_o", issue_inst1, exp_out1.inst);
        check_field("issue_pc1_o", issue_pc1, exp_out1.pc);
        check_field("issue_is_branch_o", {30'b0, issue_is_branch},
                    {30'b0, exp_out1.is_br, exp_out0.is_br});
        check_field("issue_pred_taken_o", {30'b0, issue_pred_taken},
                    {30'b0, exp_out1.pt, exp_out0.pt});
        check_field("issue_pred_target0_o", issue_pred_target0, exp_out0.tgt);
        check_field("issue_pred_target1_o", issue_pred_target1, exp_out1.tgt);
    endtask

    // One cycle that starts and ends 1 ns after a rising edge
    task automatic apply_step(input step_t s);
        int         occ;
        int         cap;
        int         rd;
        logic       flush;
        logic       exp_ready;
        logic [1:0] fen;
        exp_entry_t e0;
        exp_entry_t e1;
        occ       = model_q.size();
        flush     = s.bfl | s.efl;
        exp_ready = (occ <= DEPTH - 2) && !flush && model_run;
        // Fetch only while the buffer accepts a pair
        fen = exp_ready ? s.fen : 2'b00;

        fetch_en     = fen;
        fetch_inst0  = {s.op0, 26'($urandom())};
        fetch_inst1  = {s.op1, 26'($urandom())};
        fetch_pc0    = pc_next;
        fetch_pc1    = fen[0] ? pc_next + 32'd4 : pc_next;
        pred_taken   = s.pt;
        pred_target  = $urandom() & 32'hffff_fffc;
        decode_ready = s.dr;
        branch_flush = s.bfl;
        exc_flush    = s.efl;
        pc_next      = pc_next + 32'(4 * (int'(fen[0]) + int'(fen[1])));

        e0.inst  = fetch_inst0;
        e0.pc    = fetch_pc0;
        e0.is_br = opcode_is_branch(s.op0);
        e0.pt    = (fen == 2'b01) ? s.pt : 1'b0;
        e0.tgt   = (fen == 2'b01) ? pred_target : 32'h0;
        e1.inst  = fetch_inst1;
        e1.pc    = fetch_pc1;
        e1.is_br = opcode_is_branch(s.op1);
        e1.pt    = fen[1] ? s.pt : 1'b0;
        e1.tgt   = fen[1] ? pred_target : 32'h0;

        #3;
        check_outputs(exp_ready);

        // Issue count is min(occupancy, decode capacity)
        cap = (s.dr == 2'b11) ? 2 : (s.dr[0] ? 1 : 0);
        rd  = flush ? 0 : ((occ < cap) ? occ : cap);
        exp_valid = 2'b00;
        exp_out0  = '0;
        exp_out1  = '0;
        if (rd >= 1) begin
            exp_out0  = model_q.pop_front();
            exp_valid = 2'b01;
        end
        if (rd == 2) begin
            exp_out1  = model_q.pop_front();
            exp_valid = 2'b11;
        end
        if (flush) begin
            model_q.delete();
        end else begin
            if (fen[0]) model_q.push_back(e0);
            if (fen[1]) model_q.push_back(e1);
        end
        model_run = !flush;

        @(posedge clk);
        #1;
    endtask

    task automatic wait_reset(output bit ok);
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < RESET_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        ok = (rst_n === 1'b1);
        if (!ok) $display("Timeout: reset still asserted after %0d cycles", n);
    endtask

    // Issue whatever the model still holds
    task automatic drain_buffer(output bit ok);
        int    n;
        step_t idle;
        idle = '{4'd5, 2'b00, OPC_ALU, OPC_ALU, 1'b0, 2'b11, 1'b0, 1'b0, 6'd1};
        n    = 0;
        while ((model_q.size() != 0 || exp_valid != 2'b00) && n < DRAIN_LIMIT) begin
            apply_step(idle);
            n++;
        end
        ok = (model_q.size() == 0 && exp_valid == 2'b00);
        if (!ok) $display("Timeout: buffer still holds entries after %0d cycles", n);
    endtask

    task automatic report_group(input int g);
        tests_run++;
        if (grp_errors == 0) begin
            $display("Test %0d %s: ok, %0d checks", g, group_name(g), grp_checks);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d of %0d checks wrong", g, group_name(g),
                     grp_errors, grp_checks);
        end
        grp_checks = 0;
        grp_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        bit ok;
        int i;
        int r;
        fetch_en     = 2'b00;
        fetch_inst0  = '0;
        fetch_pc0    = '0;
        fetch_inst1  = '0;
        fetch_pc1    = '0;
        pred_taken   = 1'b0;
        pred_target  = '0;
        decode_ready = 2'b00;
        branch_flush = 1'b0;
        exc_flush    = 1'b0;
        void'($urandom(32'h3ddc_23cf));

        // Reset leaves the control in recovery with nothing issued
        model_run    = 1'b0;
        exp_valid    = 2'b00;
        exp_out0     = '0;
        exp_out1     = '0;
        pc_next      = 32'h0000_1000;
        grp_cur      = 0;
        grp_checks   = 0;
        grp_errors   = 0;
        total_checks = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        verdict_done = 1'b0;

        wait_reset(ok);
        if (ok) begin
            for (i = 0; i < NUM_STEPS; i++) begin
                if (int'(STEPS[i].grp) != grp_cur) begin
                    if (grp_cur != 0) report_group(grp_cur);
                    grp_cur = int'(STEPS[i].grp);
                end
                for (r = 0; r < int'(STEPS[i].rep); r++) begin
                    apply_step(STEPS[i]);
                end
            end
            drain_buffer(ok);
            report_group(grp_cur);
        end

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, errors);
        verdict_done = 1'b1;
        if (ok && tests_failed == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Run that ends before the main sequence completes
    final begin
        if (!verdict_done) $display("STATUS: FAIL");
    end

endmodule

//--- build.f
rtl/fetch_pkg.sv
rtl/issue_pkg.sv
rtl/ibuf_if.sv
rtl/branch_predecode.sv
rtl/inst_buffer.sv
rtl/issue_ctrl.sv
rtl/frontend_top.sv
bench/clk_gen.sv
bench/frontend_assertions.sv
bench/frontend_tb.sv

//--- rtl/branch_predecode.sv
`timescale 1ns/1ps

module branch_predecode (
    input  logic [1:0]               fetch_en_i,
    input  fetch_pkg::inst_t         inst0_i,
    input  fetch_pkg::inst_t         inst1_i,
    input  logic                     pred_taken_i,
    input  fetch_pkg::pc_t           pred_target_i,
    output fetch_pkg::branch_info_t  info0_o,
    output fetch_pkg::branch_info_t  info1_o
);

    fetch_pkg::predecode_op_e op0;
    fetch_pkg::predecode_op_e op1;
    logic                     pred_on0;
    logic                     pred_on1;

    // Map the opcode field onto the known branch opcodes
    function automatic fetch_pkg::predecode_op_e classify(input fetch_pkg::inst_t inst);
        fetch_pkg::predecode_op_e op;
        op = fetch_pkg::predecode_op_e'(inst[fetch_pkg::OPCODE_MSB:fetch_pkg::OPCODE_LSB]);
        case (op)
            fetch_pkg::OP_B,
            fetch_pkg::OP_BL,
            fetch_pkg::OP_BEQ,
            fetch_pkg::OP_BNE,
            fetch_pkg::OP_BLT: classify = op;
            default:           classify = fetch_pkg::OP_OTHER;
        endcase
    endfunction

    assign op0 = classify(inst0_i);
    assign op1 = classify(inst1_i);

    // Prediction belongs to the youngest enabled slot
    assign pred_on1 = fetch_en_i[1];
    assign pred_on0 = (fetch_en_i == 2'b01);

    always_comb begin
        info0_o.is_branch   = (op0 != fetch_pkg::OP_OTHER);
        info0_o.pred_taken  = pred_on0 ? pred_taken_i : 1'b0;
        info0_o.pred_target = pred_on0 ? pred_target_i : '0;

        info1_o.is_branch   = (op1 != fetch_pkg::OP_OTHER);
        info1_o.pred_taken  = pred_on1 ? pred_taken_i : 1'b0;
        info1_o.pred_target = pred_on1 ? pred_target_i : '0;
    end

endmodule

//--- rtl/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic words
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] inst_t;
    typedef logic [31:0] pc_t;

    // Major opcode field of an instruction word
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 26;

    ////////////////////////////////////////////////////////////////////////////
    // Branch information and buffer entry
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic is_branch;
        logic pred_taken;
        pc_t  pred_target;
    } branch_info_t;

    // One slot of the instruction buffer
    typedef struct packed {
        inst_t        inst;
        pc_t          pc;
        branch_info_t info;
    } buf_entry_t;

    // Opcodes the pre-decoder tells apart
    typedef enum logic [5:0] {
        OP_B     = 6'h14,
        OP_BL    = 6'h15,
        OP_BEQ   = 6'h16,
        OP_BNE   = 6'h17,
        OP_BLT   = 6'h18,
        OP_OTHER = 6'h3f
    } predecode_op_e;

endpackage

//--- rtl/frontend_top.sv
`timescale 1ns/1ps

module frontend_top #(
    parameter int DEPTH = 32
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [1:0]        fetch_en_i,
    input  fetch_pkg::inst_t  fetch_inst0_i,
    input  fetch_pkg::pc_t    fetch_pc0_i,
    input  fetch_pkg::inst_t  fetch_inst1_i,
    input  fetch_pkg::pc_t    fetch_pc1_i,
    input  logic              pred_taken_i,
    input  fetch_pkg::pc_t    pred_target_i,
    input  logic [1:0]        decode_ready_i,
    input  logic              branch_flush_i,
    input  logic              exc_flush_i,
    output logic              fetch_ready_o,
    output logic [1:0]        issue_valid_o,
    output fetch_pkg::inst_t  issue_inst0_o,
    output fetch_pkg::pc_t    issue_pc0_o,
    output fetch_pkg::inst_t  issue_inst1_o,
    output fetch_pkg::pc_t    issue_pc1_o,
    output logic [1:0]        issue_is_branch_o,
    output logic [1:0]        issue_pred_taken_o,
    output fetch_pkg::pc_t    issue_pred_target0_o,
    output fetch_pkg::pc_t    issue_pred_target1_o
);

    fetch_pkg::branch_info_t info0;
    fetch_pkg::branch_info_t info1;
    fetch_pkg::buf_entry_t   entry0;
    fetch_pkg::buf_entry_t   entry1;
    fetch_pkg::buf_entry_t   issue0;
    fetch_pkg::buf_entry_t   issue1;

    ibuf_if #(.DEPTH(DEPTH)) ibuf ();

    branch_predecode u_predecode (
        .fetch_en_i    (fetch_en_i),
        .inst0_i       (fetch_inst0_i),
        .inst1_i       (fetch_inst1_i),
        .pred_taken_i  (pred_taken_i),
        .pred_target_i (pred_target_i),
        .info0_o       (info0),
        .info1_o       (info1)
    );

    // Fetch slots into buffer entries
    assign entry0 = '{inst: fetch_inst0_i, pc: fetch_pc0_i, info: info0};
    assign entry1 = '{inst: fetch_inst1_i, pc: fetch_pc1_i, info: info1};

    issue_ctrl #(.DEPTH(DEPTH)) u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .ibuf           (ibuf.ctrl),
        .fetch_en_i     (fetch_en_i),
        .decode_ready_i (decode_ready_i),
        .branch_flush_i (branch_flush_i),
        .exc_flush_i    (exc_flush_i),
        .fetch_ready_o  (fetch_ready_o)
    );

    inst_buffer #(.DEPTH(DEPTH)) u_buffer (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ibuf          (ibuf.buffer),
        .entry0_i      (entry0),
        .entry1_i      (entry1),
        .issue_valid_o (issue_valid_o),
        .issue0_o      (issue0),
        .issue1_o      (issue1)
    );

    // Issue registers out to plain ports
    assign issue_inst0_o        = issue0.inst;
    assign issue_pc0_o          = issue0.pc;
    assign issue_inst1_o        = issue1.inst;
    assign issue_pc1_o          = issue1.pc;
    assign issue_is_branch_o    = {issue1.info.is_branch, issue0.info.is_branch};
    assign issue_pred_taken_o   = {issue1.info.pred_taken, issue0.info.pred_taken};
    assign issue_pred_target0_o = issue0.info.pred_target;
    assign issue_pred_target1_o = issue1.info.pred_target;

endmodule

//--- rtl/ibuf_if.sv
`timescale 1ns/1ps

interface ibuf_if #(
    parameter int DEPTH = 32
);
    localparam int CNT_W = $clog2(DEPTH) + 1;

    // Zero to two entries written this cycle
    logic [1:0]           wr_count;
    // Slot 1 arrives without slot 0
    logic                 wr_lone1;
    issue_pkg::issue_op_e rd_op;
    logic                 flush;
    // Occupancy from 0 up to DEPTH
    logic [CNT_W-1:0]     count;

    modport ctrl (
        output wr_count,
        output wr_lone1,
        output rd_op,
        output flush,
        input  count
    );

    modport buffer (
        input  wr_count,
        input  wr_lone1,
        input  rd_op,
        input  flush,
        output count
    );

endinterface

//--- rtl/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer #(
    parameter int DEPTH = 32
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    ibuf_if.buffer                ibuf,
    input  fetch_pkg::buf_entry_t entry0_i,
    input  fetch_pkg::buf_entry_t entry1_i,
    output logic [1:0]            issue_valid_o,
    output fetch_pkg::buf_entry_t issue0_o,
    output fetch_pkg::buf_entry_t issue1_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    fetch_pkg::buf_entry_t mem [DEPTH];

    // Pointers carry one extra wrap bit above the index
    logic [CNT_W-1:0] head_q;
    logic [CNT_W-1:0] tail_q;
    logic [PTR_W-1:0] head_idx;
    logic [PTR_W-1:0] tail_idx;
    logic [CNT_W-1:0] rd_num;

    assign head_idx = head_q[PTR_W-1:0];
    assign tail_idx = tail_q[PTR_W-1:0];

    // Occupancy from the pointer difference
    assign ibuf.count = tail_q - head_q;

    always_comb begin
        case (ibuf.rd_op)
            issue_pkg::ISSUE_TWO: rd_num = CNT_W'(2);
            issue_pkg::ISSUE_ONE: rd_num = CNT_W'(1);
            default:              rd_num = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i || ibuf.flush) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_q + rd_num;
            tail_q <= tail_q + CNT_W'(ibuf.wr_count);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Entry array, dual write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ibuf.wr_count != 2'd0) begin
            // Lone slot 1 goes to the tail entry
            mem[tail_idx] <= ibuf.wr_lone1 ? entry1_i : entry0_i;
        end
        if (ibuf.wr_count == 2'd2) begin
            mem[tail_idx + PTR_W'(1)] <= entry1_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue registers, dual read port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issue_valid_o <= 2'b00;
            issue0_o      <= '0;
            issue1_o      <= '0;
        end else begin
            case (ibuf.rd_op)
                issue_pkg::ISSUE_TWO: begin
                    issue_valid_o <= 2'b11;
                    issue0_o      <= mem[head_idx];
                    issue1_o      <= mem[head_idx + PTR_W'(1)];
                end
                issue_pkg::ISSUE_ONE: begin
                    issue_valid_o <= 2'b01;
                    issue0_o      <= mem[head_idx];
                    issue1_o      <= '0;
                end
                default: begin
                    // Idle slots read as zero
                    issue_valid_o <= 2'b00;
                    issue0_o      <= '0;
                    issue1_o      <= '0;
                end
            endcase
        end
    end

endmodule

//--- rtl/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl #(
    parameter int DEPTH = 32
) (
    input  logic       clk,
    input  logic       rst_n_i,
    ibuf_if.ctrl       ibuf,
    input  logic [1:0] fetch_en_i,
    input  logic [1:0] decode_ready_i,
    input  logic       branch_flush_i,
    input  logic       exc_flush_i,
    output logic       fetch_ready_o
);

    localparam int CNT_W = $clog2(DEPTH) + 1;

    issue_pkg::ctrl_state_e state_q;
    logic                   flush;
    logic                   room_for_pair;

    assign flush      = branch_flush_i | exc_flush_i;
    assign ibuf.flush = flush;

    // Fetch side
    assign ibuf.wr_count = {1'b0, fetch_en_i[0]} + {1'b0, fetch_en_i[1]};
    assign ibuf.wr_lone1 = (fetch_en_i == 2'b10);

    assign room_for_pair = (ibuf.count <= CNT_W'(DEPTH - 2));
    assign fetch_ready_o = room_for_pair && !flush && (state_q == issue_pkg::CTRL_RUN);

    // Issue count is min(occupancy, decode capacity)
    always_comb begin
        if (flush) begin
            ibuf.rd_op = issue_pkg::ISSUE_NONE;
        end else if (decode_ready_i == 2'b11 && ibuf.count >= CNT_W'(2)) begin
            ibuf.rd_op = issue_pkg::ISSUE_TWO;
        end else if (decode_ready_i[0] && ibuf.count != '0) begin
            ibuf.rd_op = issue_pkg::ISSUE_ONE;
        end else begin
            ibuf.rd_op = issue_pkg::ISSUE_NONE;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Recovery state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= issue_pkg::CTRL_RECOVER;
        end else if (flush) begin
            state_q <= issue_pkg::CTRL_RECOVER;
        end else begin
            state_q <= issue_pkg::CTRL_RUN;
        end
    end

endmodule

//--- rtl/issue_pkg.sv
package issue_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Issue control types
    ////////////////////////////////////////////////////////////////////////////

    // Number of entries read from the buffer in one cycle
    typedef enum logic [1:0] {
        ISSUE_NONE = 2'd0,
        ISSUE_ONE  = 2'd1,
        ISSUE_TWO  = 2'd2
    } issue_op_e;

    // Recover lasts one cycle after reset or flush
    typedef enum logic {
        CTRL_RUN     = 1'b0,
        CTRL_RECOVER = 1'b1
    } ctrl_state_e;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
BIN=frontend_sim

verilator --binary --timing --assert -j 0 \
    --top-module frontend_tb \
    --Mdir "$OBJ_DIR" \
    -o "$BIN" \
    -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$OBJ_DIR/$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
